// ==== hw/pwo_arith_pkg.sv ====
/*
  Arithmetic constants and types for the point-wise engine.
  Fixed at N = 32 coefficients modulo q = 3329.
  Barrett constants assume an unreduced value below 2^24, which leaves
  at most one conditional subtraction after the estimate.
*/

package pwo_arith_pkg;

    // Polynomial shape
    localparam int unsigned PWO_N = 32;
    localparam int unsigned PWO_Q = 3329;

    // Barrett reduction, m = floor(2^k / q)
    localparam int unsigned BARRETT_K = 24;
    localparam int unsigned BARRETT_M = 5039;

    // One reduced coefficient
    typedef logic [11:0] coef_t;

    // Product of two coefficients before reduction
    typedef logic [23:0] wide_t;

    // Coefficient index
    typedef logic [4:0] addr_t;

endpackage

// ==== hw/pwo_axil_regs.sv ====
/*
  AXI4-Lite slave for control, mode, status and the three memory windows.
  Single beats only, WSTRB is ignored. AW and W are taken together.
  Register reads answer one cycle after AR, window reads two.
  Window accesses while busy get SLVERR and never reach the RAMs.
  Mode writes while busy are dropped so the engine sees stable levels.
*/
`timescale 1ns/10ps

module pwo_axil_regs (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [11:0]               awaddr,
    input  logic                      wvalid,
    output logic                      wready,
    input  logic [31:0]               wdata,
    input  logic [3:0]                wstrb,
    output logic                      bvalid,
    input  logic                      bready,
    output logic [1:0]                bresp,
    input  logic                      arvalid,
    output logic                      arready,
    input  logic [11:0]               araddr,
    output logic                      rvalid,
    input  logic                      rready,
    output logic [31:0]               rdata,
    output logic [1:0]                rresp,
    output logic                      start_pulse,
    output logic                      zeroize_pulse,
    output pwo_regmap_pkg::pwo_mode_t mode,
    output logic                      accumulate,
    input  logic                      busy,
    input  logic                      done,
    output logic                      mem_a_en,
    output logic                      mem_a_we,
    output pwo_arith_pkg::addr_t      mem_a_addr,
    output pwo_arith_pkg::coef_t      mem_a_wdata,
    input  pwo_arith_pkg::coef_t      mem_a_rdata,
    output logic                      mem_b_en,
    output logic                      mem_b_we,
    output pwo_arith_pkg::addr_t      mem_b_addr,
    output pwo_arith_pkg::coef_t      mem_b_wdata,
    input  pwo_arith_pkg::coef_t      mem_b_rdata,
    output logic                      mem_c_en,
    output logic                      mem_c_we,
    output pwo_arith_pkg::addr_t      mem_c_addr,
    output pwo_arith_pkg::coef_t      mem_c_wdata,
    input  pwo_arith_pkg::coef_t      mem_c_rdata
);

    typedef enum logic [1:0] {
        rs_idle,
        rs_mem,
        rs_resp
    } rd_state_t;

    rd_state_t            rd_state;
    logic                 wr_hs;
    logic                 rd_hs;
    logic                 wr_a, wr_b, wr_c, wr_win;
    logic                 rd_a, rd_b, rd_c, rd_win;
    pwo_arith_pkg::addr_t win_idx;
    logic [1:0]           mem_sel;
    pwo_arith_pkg::coef_t mem_rdata_sel;
    logic [31:0]          reg_rdata;

    function automatic logic in_window(input logic [11:0] addr, input logic [11:0] base);
        return addr[11:7] == base[11:7];
    endfunction

    // A pending response blocks the next handshake on its channel
    assign wr_hs   = awvalid && wvalid && !bvalid;
    assign awready = wr_hs;
    assign wready  = wr_hs;
    assign rd_hs   = arvalid && (rd_state == rs_idle) && !wr_hs;
    assign arready = rd_hs;

    assign wr_a   = in_window(awaddr, pwo_regmap_pkg::MEM_A_BASE);
    assign wr_b   = in_window(awaddr, pwo_regmap_pkg::MEM_B_BASE);
    assign wr_c   = in_window(awaddr, pwo_regmap_pkg::MEM_C_BASE);
    assign wr_win = wr_a || wr_b || wr_c;
    assign rd_a   = in_window(araddr, pwo_regmap_pkg::MEM_A_BASE);
    assign rd_b   = in_window(araddr, pwo_regmap_pkg::MEM_B_BASE);
    assign rd_c   = in_window(araddr, pwo_regmap_pkg::MEM_C_BASE);
    assign rd_win = rd_a || rd_b || rd_c;

    // ==================================================================
    // Memory window ports
    // ==================================================================
    assign win_idx = wr_hs ? awaddr[6:2] : araddr[6:2];

    assign mem_a_en    = !busy && ((wr_hs && wr_a) || (rd_hs && rd_a));
    assign mem_a_we    = !busy && wr_hs && wr_a;
    assign mem_a_addr  = win_idx;
    assign mem_a_wdata = wdata[11:0];
    assign mem_b_en    = !busy && ((wr_hs && wr_b) || (rd_hs && rd_b));
    assign mem_b_we    = !busy && wr_hs && wr_b;
    assign mem_b_addr  = win_idx;
    assign mem_b_wdata = wdata[11:0];
    assign mem_c_en    = !busy && ((wr_hs && wr_c) || (rd_hs && rd_c));
    assign mem_c_we    = !busy && wr_hs && wr_c;
    assign mem_c_addr  = win_idx;
    assign mem_c_wdata = wdata[11:0];

    // ==================================================================
    // Write channel and registers
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid        <= 1'b0;
            bresp         <= pwo_regmap_pkg::RESP_OKAY;
            start_pulse   <= 1'b0;
            zeroize_pulse <= 1'b0;
            mode          <= pwo_regmap_pkg::op_pwm;
            accumulate    <= 1'b0;
        end else begin
            start_pulse   <= 1'b0;
            zeroize_pulse <= 1'b0;
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (wr_hs) begin
                bvalid <= 1'b1;
                bresp  <= (wr_win && busy) ? pwo_regmap_pkg::RESP_SLVERR
                                           : pwo_regmap_pkg::RESP_OKAY;
                if (awaddr == pwo_regmap_pkg::REG_CTRL) begin
                    start_pulse   <= wdata[pwo_regmap_pkg::CTRL_START_BIT];
                    zeroize_pulse <= wdata[pwo_regmap_pkg::CTRL_ZERO_BIT];
                end
                if (awaddr == pwo_regmap_pkg::REG_MODE && !busy) begin
                    mode       <= pwo_regmap_pkg::pwo_mode_t'(wdata[1:0]);
                    accumulate <= wdata[pwo_regmap_pkg::MODE_ACC_BIT];
                end
            end
        end
    end

    // ==================================================================
    // Read channel
    // ==================================================================
    always_comb begin
        reg_rdata = '0;
        case (araddr)
            pwo_regmap_pkg::REG_MODE: begin
                reg_rdata[1:0]                         = mode;
                reg_rdata[pwo_regmap_pkg::MODE_ACC_BIT] = accumulate;
            end
            pwo_regmap_pkg::REG_STATUS: begin
                reg_rdata[pwo_regmap_pkg::STAT_BUSY_BIT] = busy;
                reg_rdata[pwo_regmap_pkg::STAT_DONE_BIT] = done;
            end
            default: reg_rdata = '0;
        endcase
    end

    always_comb begin
        case (mem_sel)
            2'd1:    mem_rdata_sel = mem_a_rdata;
            2'd2:    mem_rdata_sel = mem_b_rdata;
            default: mem_rdata_sel = mem_c_rdata;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_state <= rs_idle;
            mem_sel  <= '0;
            rdata    <= '0;
            rresp    <= pwo_regmap_pkg::RESP_OKAY;
        end else begin
            case (rd_state)
                rs_idle: begin
                    if (rd_hs) begin
                        mem_sel <= rd_a ? 2'd1 : (rd_b ? 2'd2 : 2'd3);
                        if (rd_win && !busy) begin
                            rd_state <= rs_mem;
                        end else begin
                            rd_state <= rs_resp;
                            rdata    <= rd_win ? '0 : reg_rdata;
                            rresp    <= rd_win ? pwo_regmap_pkg::RESP_SLVERR
                                               : pwo_regmap_pkg::RESP_OKAY;
                        end
                    end
                end
                // RAM data is valid one cycle after the enable
                rs_mem: begin
                    rdata    <= 32'(mem_rdata_sel);
                    rresp    <= pwo_regmap_pkg::RESP_OKAY;
                    rd_state <= rs_resp;
                end
                rs_resp: begin
                    if (rready) begin
                        rd_state <= rs_idle;
                    end
                end
                default: rd_state <= rs_idle;
            endcase
        end
    end

    assign rvalid = (rd_state == rs_resp);

endmodule

// ==== hw/pwo_coef_ram.sv ====
/*
  Two-port coefficient memory in flops, 32 x 12 bits.
  Read data is registered, one cycle after the enable.
  Zeroize clears every entry in one cycle; a same-address write on
  both ports keeps the port b data.
*/
`timescale 1ns/10ps

module pwo_coef_ram (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 zeroize,
    input  logic                 ena,
    input  logic                 wea,
    input  pwo_arith_pkg::addr_t addra,
    input  pwo_arith_pkg::coef_t dina,
    output pwo_arith_pkg::coef_t douta,
    input  logic                 enb,
    input  logic                 web,
    input  pwo_arith_pkg::addr_t addrb,
    input  pwo_arith_pkg::coef_t dinb,
    output pwo_arith_pkg::coef_t doutb
);

    pwo_arith_pkg::coef_t mem [pwo_arith_pkg::PWO_N];

    // Storage, port b written last so it wins
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem <= '{default: '0};
        end else if (zeroize) begin
            mem <= '{default: '0};
        end else begin
            if (ena && wea) begin
                mem[addra] <= dina;
            end
            if (enb && web) begin
                mem[addrb] <= dinb;
            end
        end
    end

    // Registered reads return the old word on a write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            douta <= '0;
            doutb <= '0;
        end else begin
            if (ena) begin
                douta <= mem[addra];
            end
            if (enb) begin
                doutb <= mem[addrb];
            end
        end
    end

endmodule

// ==== hw/pwo_mod_alu.sv ====
/*
  Two-stage modular ALU for multiply, add and subtract mod q.
  Operands enter with valid_in; the result is valid two cycles later
  and holds until the next item. mode and accumulate must stay stable
  while items are in flight. Inputs must already be below q.
*/
`timescale 1ns/10ps

module pwo_mod_alu (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      valid_in,
    input  pwo_regmap_pkg::pwo_mode_t mode,
    input  logic                      accumulate,
    input  pwo_arith_pkg::coef_t      a,
    input  pwo_arith_pkg::coef_t      b,
    input  pwo_arith_pkg::coef_t      c_prev,
    output pwo_arith_pkg::coef_t      result
);

    pwo_arith_pkg::wide_t raw_d;
    pwo_arith_pkg::wide_t raw_q;
    pwo_arith_pkg::coef_t c_prev_q;
    logic                 valid_q;
    logic [36:0]          bar_prod;
    pwo_arith_pkg::wide_t quot;
    pwo_arith_pkg::wide_t rem_wide;
    logic [12:0]          rem;
    logic [12:0]          red;
    logic [12:0]          acc_sum;
    logic [12:0]          acc_red;

    // ==================================================================
    // Stage 1: raw value
    // ==================================================================
    always_comb begin
        case (mode)
            pwo_regmap_pkg::op_pwa:
                raw_d = pwo_arith_pkg::wide_t'(a) + pwo_arith_pkg::wide_t'(b);
            // Adding q first keeps the difference positive
            pwo_regmap_pkg::op_pws:
                raw_d = pwo_arith_pkg::wide_t'(a) + pwo_arith_pkg::wide_t'(pwo_arith_pkg::PWO_Q)
                        - pwo_arith_pkg::wide_t'(b);
            default:
                raw_d = pwo_arith_pkg::wide_t'(a) * pwo_arith_pkg::wide_t'(b);
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_in) begin
            raw_q    <= raw_d;
            c_prev_q <= c_prev;
        end
    end

    // ==================================================================
    // Stage 2: Barrett reduction and optional accumulate
    // ==================================================================
    assign bar_prod = raw_q * 37'(pwo_arith_pkg::BARRETT_M);
    assign quot     = pwo_arith_pkg::wide_t'(bar_prod >> pwo_arith_pkg::BARRETT_K);
    assign rem_wide = raw_q - quot * pwo_arith_pkg::wide_t'(pwo_arith_pkg::PWO_Q);

    // Estimate is low by at most one q
    assign rem = rem_wide[12:0];
    assign red = (rem >= 13'(pwo_arith_pkg::PWO_Q)) ? rem - 13'(pwo_arith_pkg::PWO_Q) : rem;

    assign acc_sum = red + 13'(c_prev_q);
    assign acc_red = (acc_sum >= 13'(pwo_arith_pkg::PWO_Q)) ?
                     acc_sum - 13'(pwo_arith_pkg::PWO_Q) : acc_sum;

    always_ff @(posedge clk) begin
        if (valid_q) begin
            result <= accumulate ? acc_red[11:0] : red[11:0];
        end
    end

endmodule

// ==== hw/pwo_regmap_pkg.sv ====
/*
  Register map of the AXI4-Lite slave and the operation mode encoding.
  Byte addresses are 12 bits; each memory window holds 32 words at a
  4-byte stride and only bits 11:0 of a coefficient are stored.
*/

package pwo_regmap_pkg;

    // Point-wise operations, no butterfly modes
    typedef enum logic [1:0] {
        op_pwm = 2'd0,
        op_pwa = 2'd1,
        op_pws = 2'd2
    } pwo_mode_t;

    // Registers
    localparam logic [11:0] REG_CTRL   = 12'h000;
    localparam logic [11:0] REG_MODE   = 12'h004;
    localparam logic [11:0] REG_STATUS = 12'h008;

    // Memory windows
    localparam logic [11:0] MEM_A_BASE = 12'h100;
    localparam logic [11:0] MEM_B_BASE = 12'h200;
    localparam logic [11:0] MEM_C_BASE = 12'h300;

    // Bit positions
    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_ZERO_BIT  = 1;
    localparam int MODE_ACC_BIT   = 4;
    localparam int STAT_BUSY_BIT  = 0;
    localparam int STAT_DONE_BIT  = 1;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// ==== hw/pwo_sequencer.sv ====
/*
  Index sequencer for one point-wise pass over 32 coefficients.
  Reads are issued on busy cycles 0..31; each write-back follows its
  read by three cycles, so busy lasts 35 cycles. Start is ignored while
  busy; zeroize aborts a run and clears done.
*/
`timescale 1ns/10ps

module pwo_sequencer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic                 zeroize,
    output logic                 rd_en,
    output pwo_arith_pkg::addr_t rd_addr,
    output logic                 alu_valid,
    output logic                 wr_en,
    output pwo_arith_pkg::addr_t wr_addr,
    output logic                 busy,
    output logic                 done
);

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_drain
    } seq_state_t;

    seq_state_t           state;
    pwo_arith_pkg::addr_t idx;
    logic [2:0]           pipe_vld;
    pwo_arith_pkg::addr_t pipe_addr [3];
    logic                 last_wr;

    assign rd_en     = (state == st_run);
    assign rd_addr   = idx;
    assign busy      = (state != st_idle);
    assign alu_valid = pipe_vld[0];
    assign wr_en     = pipe_vld[2];
    assign wr_addr   = pipe_addr[2];
    assign last_wr   = wr_en && (wr_addr == pwo_arith_pkg::addr_t'(pwo_arith_pkg::PWO_N - 1));

    // ==================================================================
    // Control FSM
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            idx   <= '0;
            done  <= 1'b0;
        end else if (zeroize) begin
            state <= st_idle;
            idx   <= '0;
            done  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_run;
                        idx   <= '0;
                        done  <= 1'b0;
                    end
                end
                st_run: begin
                    // Index wraps back to zero after the last read
                    idx <= idx + 1'b1;
                    if (idx == pwo_arith_pkg::addr_t'(pwo_arith_pkg::PWO_N - 1)) begin
                        state <= st_drain;
                    end
                end
                st_drain: begin
                    if (last_wr) begin
                        state <= st_idle;
                        done  <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Stage 0 is RAM latency, stages 1 and 2 follow the ALU
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pipe_vld <= '0;
        end else if (zeroize) begin
            pipe_vld <= '0;
        end else begin
            pipe_vld <= {pipe_vld[1:0], rd_en};
        end
    end

    always_ff @(posedge clk) begin
        pipe_addr[0] <= rd_addr;
        pipe_addr[1] <= pipe_addr[0];
        pipe_addr[2] <= pipe_addr[1];
    end

endmodule

// ==== hw/pwo_top.sv ====
/*
  Point-wise polynomial engine with an AXI4-Lite slave.
  Port a of each memory serves the bus, port b the engine.
  While busy the bus is locked out of the windows, so port a of C
  carries the accumulate reads and port b of C takes the write-back.
*/
`timescale 1ns/10ps

module pwo_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        awvalid,
    output logic        awready,
    input  logic [11:0] awaddr,
    input  logic        wvalid,
    output logic        wready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    output logic        bvalid,
    input  logic        bready,
    output logic [1:0]  bresp,
    input  logic        arvalid,
    output logic        arready,
    input  logic [11:0] araddr,
    output logic        rvalid,
    input  logic        rready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp
);

    logic                      start_pulse, zeroize_pulse, accumulate, busy, done;
    pwo_regmap_pkg::pwo_mode_t mode;
    logic                      rd_en, alu_valid, wr_en;
    pwo_arith_pkg::addr_t      rd_addr, wr_addr;
    pwo_arith_pkg::coef_t      alu_result, a_rd, b_rd;
    logic                      mem_a_en, mem_a_we, mem_b_en, mem_b_we, mem_c_en, mem_c_we;
    pwo_arith_pkg::addr_t      mem_a_addr, mem_b_addr, mem_c_addr;
    pwo_arith_pkg::coef_t      mem_a_wdata, mem_b_wdata, mem_c_wdata;
    pwo_arith_pkg::coef_t      mem_a_rdata, mem_b_rdata, mem_c_rdata;
    logic                      c_ena, c_wea;
    pwo_arith_pkg::addr_t      c_addra;

    // Engine takes port a of C for the run
    assign c_ena   = busy ? rd_en : mem_c_en;
    assign c_wea   = !busy && mem_c_we;
    assign c_addra = busy ? rd_addr : mem_c_addr;

    pwo_axil_regs u_regs (
        .clk(clk), .rst_n(rst_n),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
        .bvalid(bvalid), .bready(bready), .bresp(bresp),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
        .start_pulse(start_pulse), .zeroize_pulse(zeroize_pulse),
        .mode(mode), .accumulate(accumulate), .busy(busy), .done(done),
        .mem_a_en(mem_a_en), .mem_a_we(mem_a_we), .mem_a_addr(mem_a_addr),
        .mem_a_wdata(mem_a_wdata), .mem_a_rdata(mem_a_rdata),
        .mem_b_en(mem_b_en), .mem_b_we(mem_b_we), .mem_b_addr(mem_b_addr),
        .mem_b_wdata(mem_b_wdata), .mem_b_rdata(mem_b_rdata),
        .mem_c_en(mem_c_en), .mem_c_we(mem_c_we), .mem_c_addr(mem_c_addr),
        .mem_c_wdata(mem_c_wdata), .mem_c_rdata(mem_c_rdata)
    );

    pwo_sequencer u_seq (
        .clk(clk), .rst_n(rst_n),
        .start(start_pulse), .zeroize(zeroize_pulse),
        .rd_en(rd_en), .rd_addr(rd_addr), .alu_valid(alu_valid),
        .wr_en(wr_en), .wr_addr(wr_addr), .busy(busy), .done(done)
    );

    pwo_mod_alu u_alu (
        .clk(clk), .rst_n(rst_n), .valid_in(alu_valid),
        .mode(mode), .accumulate(accumulate),
        .a(a_rd), .b(b_rd), .c_prev(mem_c_rdata), .result(alu_result)
    );

    pwo_coef_ram u_mem_a (
        .clk(clk), .rst_n(rst_n), .zeroize(zeroize_pulse),
        .ena(mem_a_en), .wea(mem_a_we), .addra(mem_a_addr),
        .dina(mem_a_wdata), .douta(mem_a_rdata),
        .enb(rd_en), .web(1'b0), .addrb(rd_addr), .dinb('0), .doutb(a_rd)
    );

    pwo_coef_ram u_mem_b (
        .clk(clk), .rst_n(rst_n), .zeroize(zeroize_pulse),
        .ena(mem_b_en), .wea(mem_b_we), .addra(mem_b_addr),
        .dina(mem_b_wdata), .douta(mem_b_rdata),
        .enb(rd_en), .web(1'b0), .addrb(rd_addr), .dinb('0), .doutb(b_rd)
    );

    pwo_coef_ram u_mem_c (
        .clk(clk), .rst_n(rst_n), .zeroize(zeroize_pulse),
        .ena(c_ena), .wea(c_wea), .addra(c_addra),
        .dina(mem_c_wdata), .douta(mem_c_rdata),
        .enb(wr_en), .web(wr_en), .addrb(wr_addr), .dinb(alu_result), .doutb()
    );

endmodule

// ==== project.f ====
hw/pwo_arith_pkg.sv
hw/pwo_regmap_pkg.sv
hw/pwo_coef_ram.sv
hw/pwo_mod_alu.sv
hw/pwo_sequencer.sv
hw/pwo_axil_regs.sv
hw/pwo_top.sv
test/tb_pwo_top.sv

// ==== test/tb_pwo_top.sv ====
/*
  Testbench for the point-wise engine over AXI4-Lite.
  Inputs change on the falling edge.
  Outputs are read during the low phase of the clock.
  Expected C comes from an integer model using the % operator.
  Operands are random mod q from a fixed seed, or the extremes 0 and q-1.
*/
`timescale 1ns/10ps

module tb_pwo_top;

    localparam int Q        = 3329;
    localparam int N        = 32;
    localparam int NUM_ROWS = 8;
    // Per row: loads, then up to two runs with a full C readback each
    localparam int TIMEOUT_CYCLES = NUM_ROWS * (64 * 4 + 2 * (32 * 5 + 40)) + 5 * (32 * 5) + 500;

    typedef struct packed {
        pwo_regmap_pkg::pwo_mode_t mode;
        logic                      acc;
        logic [5:0]                n_rand;
    } row_t;

    logic        clk;
    logic        rst_n;
    logic        awvalid, wvalid, bready, arvalid, rready;
    logic [11:0] awaddr, araddr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        awready, wready, bvalid, arready, rvalid;
    logic [1:0]  bresp, rresp;
    logic [31:0] rdata;

    row_t   rows [NUM_ROWS];
    int     a_model [N];
    int     b_model [N];
    int     c_model [N];
    integer seed;
    int     cycle_count;
    int     errors;
    int     errors_at_start;
    int     tests_passed;
    int     tests_failed;

    pwo_top u_dut (
        .clk(clk), .rst_n(rst_n),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
        .bvalid(bvalid), .bready(bready), .bresp(bresp),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Watchdog
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the DUT stopped answering", cycle_count);
        $display("TEST FAILED");
        $finish;
    end

    // ==================================================================
    // Bus tasks
    // ==================================================================
    task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        // AW and W must be taken together on one edge
        #1;
        while (!awready || !wready) begin
            if (awready != wready) report_mismatch("wready", awready, wready);
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        // bvalid rises on the edge that took AW and W
        while (!bvalid) @(negedge clk);
        resp = bresp;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [11:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        #1;
        while (!arready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        data = rdata;
        resp = rresp;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("ERROR at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        errors++;
    endtask

    task automatic close_test(input string name);
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("%s: PASS", name);
        end else begin
            tests_failed++;
            $display("%s: FAIL with %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    // ==================================================================
    // Reference model
    // ==================================================================
    function automatic int op_result(input pwo_regmap_pkg::pwo_mode_t mode, input int a, input int b);
        case (mode)
            pwo_regmap_pkg::op_pwa: return (a + b) % Q;
            pwo_regmap_pkg::op_pws: return (a - b + Q) % Q;
            default:                return (a * b) % Q;
        endcase
    endfunction

    task automatic apply_model(input pwo_regmap_pkg::pwo_mode_t mode, input logic acc);
        for (int i = 0; i < N; i++) begin
            if (acc) begin
                c_model[i] = (c_model[i] + op_result(mode, a_model[i], b_model[i])) % Q;
            end else begin
                c_model[i] = op_result(mode, a_model[i], b_model[i]);
            end
        end
    endtask

    // ==================================================================
    // Test steps
    // ==================================================================
    // First n_rand words random, the rest walk through the extremes
    task automatic load_operands(input int n_rand);
        logic [1:0] resp;
        for (int i = 0; i < N; i++) begin
            if (i < n_rand) begin
                a_model[i] = {$random(seed)} % Q;
                b_model[i] = {$random(seed)} % Q;
            end else begin
                a_model[i] = (i % 2 != 0) ? Q - 1 : 0;
                b_model[i] = ((i / 2) % 2 != 0) ? Q - 1 : 0;
            end
            axi_write(pwo_regmap_pkg::MEM_A_BASE + 12'(4 * i), 32'(a_model[i]), resp);
            if (resp != pwo_regmap_pkg::RESP_OKAY) report_mismatch("bresp", 0, resp);
            axi_write(pwo_regmap_pkg::MEM_B_BASE + 12'(4 * i), 32'(b_model[i]), resp);
            if (resp != pwo_regmap_pkg::RESP_OKAY) report_mismatch("bresp", 0, resp);
        end
    endtask

    task automatic set_mode(input pwo_regmap_pkg::pwo_mode_t mode, input logic acc);
        logic [1:0] resp;
        axi_write(pwo_regmap_pkg::REG_MODE,
                  32'(mode) | (32'(acc) << pwo_regmap_pkg::MODE_ACC_BIT), resp);
        if (resp != pwo_regmap_pkg::RESP_OKAY) report_mismatch("bresp", 0, resp);
    endtask

    task automatic start_engine;
        logic [1:0] resp;
        axi_write(pwo_regmap_pkg::REG_CTRL, 32'h1 << pwo_regmap_pkg::CTRL_START_BIT, resp);
        if (resp != pwo_regmap_pkg::RESP_OKAY) report_mismatch("bresp", 0, resp);
    endtask

    task automatic wait_done;
        logic [31:0] data;
        logic [1:0]  resp;
        data = '0;
        while (!data[pwo_regmap_pkg::STAT_DONE_BIT] || data[pwo_regmap_pkg::STAT_BUSY_BIT]) begin
            axi_read(pwo_regmap_pkg::REG_STATUS, data, resp);
        end
    endtask

    task automatic compare_mem(input logic [11:0] base, input string tag, input logic zero);
        logic [31:0] data;
        logic [1:0]  resp;
        for (int i = 0; i < N; i++) begin
            axi_read(base + 12'(4 * i), data, resp);
            if (resp != pwo_regmap_pkg::RESP_OKAY) report_mismatch("rresp", 0, resp);
            if (data != 32'(zero ? 0 : c_model[i])) begin
                report_mismatch($sformatf("rdata %s[%0d]", tag, i), zero ? 0 : c_model[i], data);
            end
        end
    endtask

    // ==================================================================
    // Main sequence
    // ==================================================================
    initial begin
        logic [31:0] data;
        logic [1:0]  resp;

        rst_n   = 1'b0;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        awaddr  = '0;
        wdata   = '0;
        wstrb   = 4'hf;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;
        seed    = 32'h3326;
        errors          = 0;
        errors_at_start = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        for (int i = 0; i < N; i++) c_model[i] = 0;

        rows[0] = '{pwo_regmap_pkg::op_pwm, 1'b0, 6'd32};
        rows[1] = '{pwo_regmap_pkg::op_pwa, 1'b0, 6'd32};
        rows[2] = '{pwo_regmap_pkg::op_pws, 1'b0, 6'd32};
        rows[3] = '{pwo_regmap_pkg::op_pwm, 1'b0, 6'd0};
        rows[4] = '{pwo_regmap_pkg::op_pwa, 1'b1, 6'd16};
        rows[5] = '{pwo_regmap_pkg::op_pws, 1'b1, 6'd0};
        rows[6] = '{pwo_regmap_pkg::op_pwm, 1'b1, 6'd32};
        rows[7] = '{pwo_regmap_pkg::op_pws, 1'b0, 6'd16};

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Reset values
        axi_read(pwo_regmap_pkg::REG_STATUS, data, resp);
        if (data != 0) report_mismatch("REG_STATUS", 0, data);
        axi_read(pwo_regmap_pkg::REG_MODE, data, resp);
        if (data != 0) report_mismatch("REG_MODE", 0, data);
        compare_mem(pwo_regmap_pkg::MEM_C_BASE, "C", 1'b1);
        close_test("reset state");

        // Table rows, accumulate rows run twice on the same operands
        for (int r = 0; r < NUM_ROWS; r++) begin
            load_operands(rows[r].n_rand);
            set_mode(rows[r].mode, rows[r].acc);
            start_engine();
            wait_done();
            apply_model(rows[r].mode, rows[r].acc);
            compare_mem(pwo_regmap_pkg::MEM_C_BASE, "C", 1'b0);
            if (rows[r].acc) begin
                start_engine();
                wait_done();
                apply_model(rows[r].mode, rows[r].acc);
                compare_mem(pwo_regmap_pkg::MEM_C_BASE, "C", 1'b0);
            end
            close_test($sformatf("row %0d mode %0d acc %0d", r, rows[r].mode, rows[r].acc));
        end

        // Window access during a run
        set_mode(pwo_regmap_pkg::op_pwa, 1'b0);
        start_engine();
        data = '0;
        while (!data[pwo_regmap_pkg::STAT_BUSY_BIT] && !data[pwo_regmap_pkg::STAT_DONE_BIT]) begin
            axi_read(pwo_regmap_pkg::REG_STATUS, data, resp);
        end
        if (!data[pwo_regmap_pkg::STAT_BUSY_BIT]) begin
            $display("Run finished before busy was seen, window access not tried");
            errors++;
        end
        // C[0] is already written back at this point of the run
        axi_write(pwo_regmap_pkg::MEM_C_BASE, 32'h0abc, resp);
        if (resp != pwo_regmap_pkg::RESP_SLVERR) report_mismatch("bresp", 2, resp);
        axi_read(pwo_regmap_pkg::MEM_A_BASE, data, resp);
        if (resp != pwo_regmap_pkg::RESP_SLVERR) report_mismatch("rresp", 2, resp);
        if (data != 0) report_mismatch("rdata", 0, data);
        wait_done();
        apply_model(pwo_regmap_pkg::op_pwa, 1'b0);
        compare_mem(pwo_regmap_pkg::MEM_C_BASE, "C", 1'b0);
        close_test("access while busy");

        // Zeroize after a completed run
        axi_write(pwo_regmap_pkg::REG_CTRL, 32'h1 << pwo_regmap_pkg::CTRL_ZERO_BIT, resp);
        if (resp != pwo_regmap_pkg::RESP_OKAY) report_mismatch("bresp", 0, resp);
        compare_mem(pwo_regmap_pkg::MEM_A_BASE, "A", 1'b1);
        compare_mem(pwo_regmap_pkg::MEM_B_BASE, "B", 1'b1);
        compare_mem(pwo_regmap_pkg::MEM_C_BASE, "C", 1'b1);
        axi_read(pwo_regmap_pkg::REG_STATUS, data, resp);
        if (data != 0) report_mismatch("REG_STATUS", 0, data);
        close_test("zeroize");

        $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
